// ==== design/mini_cluster_pkg.sv ====
/* Mini cluster package
   Widths, opcodes, peripheral map and the instruction word layouts */
package mini_cluster_pkg;

  localparam int unsigned XLEN         = 16;
  localparam int unsigned ILEN         = 16;
  localparam int unsigned PcWidth      = 8;
  localparam int unsigned BusAddrWidth = 9;
  localparam int unsigned NrRegs       = 16;

  // Peripheral offsets, selected when bus address bit 8 is set
  localparam logic AddrEntry = 1'b0;
  localparam logic AddrMsip  = 1'b1;

  // Opcode 0 and 8..15 decode as no-operation
  typedef enum logic [3:0] {
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_XOR  = 4'h4,
    OP_LI   = 4'h5,
    OP_ADDI = 4'h6,
    OP_WFI  = 4'h7
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_AND = 2'd2,
    ALU_XOR = 2'd3
  } alu_op_e;

  // One word, two views: register format and immediate format
  typedef union packed {
    struct packed {
      opcode_e    opcode;
      logic [3:0] rd;
      logic [3:0] rs1;
      logic [3:0] rs2;
    } r_fmt;
    struct packed {
      opcode_e    opcode;
      logic [3:0] rd;
      logic [7:0] imm;
    } i_fmt;
  } insn_u;

endpackage

// ==== design/cluster_periph.sv ====
/* Cluster peripherals
   Entry-point scratch register and the software interrupt (msip) bit */
module cluster_periph (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               periph_we_i,
  input  logic                               periph_offset_i,
  input  logic [mini_cluster_pkg::XLEN-1:0]    periph_wdata_i,
  input  logic                               sleep_enter_i,
  output logic [mini_cluster_pkg::PcWidth-1:0] entry_pc_o,
  output logic                               msip_o
);

  import mini_cluster_pkg::*;

  logic entry_we;
  logic msip_we;
  logic msip_q;

  assign entry_we = periph_we_i && (periph_offset_i == AddrEntry);
  assign msip_we  = periph_we_i && (periph_offset_i == AddrMsip);

  // Entry point keeps only the low bits of the written word
  always_ff @(posedge clk_i) begin
    if (entry_we) begin
      entry_pc_o <= periph_wdata_i[PcWidth-1:0];
    end
  end

  // Bus write wins over the clear from sleep entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      msip_q <= 1'b0;
    end else if (msip_we) begin
      msip_q <= periph_wdata_i[0];
    end else if (sleep_enter_i) begin
      msip_q <= 1'b0;
    end
  end

  assign msip_o = msip_q;

endmodule

// ==== design/instr_mem.sv ====
/* Instruction memory
   256 words, written from the bus, read one cycle after a fetch request */
module instr_mem (
  input  logic                               clk_i,
  input  logic                               mem_we_i,
  input  logic [mini_cluster_pkg::PcWidth-1:0] mem_waddr_i,
  input  logic [mini_cluster_pkg::ILEN-1:0]    mem_wdata_i,
  input  logic                               fetch_en_i,
  input  logic [mini_cluster_pkg::PcWidth-1:0] fetch_pc_i,
  output mini_cluster_pkg::insn_u            fetch_insn_o
);

  import mini_cluster_pkg::*;

  localparam int unsigned NrWords = 2 ** PcWidth;

  logic [ILEN-1:0] mem_q [NrWords];

  always_ff @(posedge clk_i) begin
    if (mem_we_i) begin
      mem_q[mem_waddr_i] <= mem_wdata_i;
    end
  end

  // Output holds the last fetched word when fetch is idle
  always_ff @(posedge clk_i) begin
    if (fetch_en_i) begin
      fetch_insn_o <= mem_q[fetch_pc_i];
    end
  end

endmodule

// ==== design/insn_decode.sv ====
/* Decode stage
   Owns the PC and sleep state, decodes each word and reads its operands */
module insn_decode (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               msip_i,
  input  logic [mini_cluster_pkg::PcWidth-1:0] entry_pc_i,
  input  logic                               sleep_enter_i,
  input  mini_cluster_pkg::insn_u            fetch_insn_i,
  input  logic                               rf_we_i,
  input  logic [3:0]                         rf_waddr_i,
  input  logic [mini_cluster_pkg::XLEN-1:0]    rf_wdata_i,
  output logic [3:0]                         rf_raddr_a_o,
  output logic [3:0]                         rf_raddr_b_o,
  input  logic [mini_cluster_pkg::XLEN-1:0]    rf_rdata_a_i,
  input  logic [mini_cluster_pkg::XLEN-1:0]    rf_rdata_b_i,
  output logic                               fetch_en_o,
  output logic [mini_cluster_pkg::PcWidth-1:0] fetch_pc_o,
  output logic                               dec_valid_o,
  output mini_cluster_pkg::alu_op_e          dec_op_o,
  output logic [3:0]                         dec_rd_o,
  output logic [3:0]                         dec_rs1_o,
  output logic [3:0]                         dec_rs2_o,
  output logic [mini_cluster_pkg::XLEN-1:0]    dec_a_o,
  output logic [mini_cluster_pkg::XLEN-1:0]    dec_b_o,
  output logic                               dec_use_imm_o,
  output logic [mini_cluster_pkg::XLEN-1:0]    dec_imm_o,
  output logic                               dec_we_o,
  output logic                               dec_wfi_o,
  output logic                               sleep_o
);

  import mini_cluster_pkg::*;

  logic               sleep_q;
  logic               halt_q;
  logic               fetched_q;
  logic [PcWidth-1:0] pc_q;
  logic               is_wfi;
  alu_op_e            op_d;
  logic [3:0]         rs1_d;
  logic [3:0]         rs2_d;
  logic               use_imm_d;
  logic               we_d;
  logic [XLEN-1:0]    imm_d;
  logic [XLEN-1:0]    a_d;
  logic [XLEN-1:0]    b_d;

  // Fetch runs while awake and until a WFI has been decoded
  assign fetch_en_o = ~sleep_q & ~halt_q;
  assign fetch_pc_o = pc_q;
  assign sleep_o    = sleep_q;
  assign is_wfi     = fetched_q && (fetch_insn_i.r_fmt.opcode == OP_WFI);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sleep_q   <= 1'b1;
      halt_q    <= 1'b0;
      fetched_q <= 1'b0;
      pc_q      <= '0;
    end else begin
      // The word behind a WFI is squashed here
      fetched_q <= fetch_en_o & ~is_wfi;
      if (sleep_enter_i) begin
        sleep_q <= 1'b1;
        halt_q  <= 1'b0;
      end else if (sleep_q && msip_i) begin
        sleep_q <= 1'b0;
        pc_q    <= entry_pc_i;
      end else if (is_wfi) begin
        halt_q <= 1'b1;
      end else if (fetch_en_o) begin
        pc_q <= pc_q + 1'b1;
      end
    end
  end

  always_comb begin
    op_d      = ALU_ADD;
    rs1_d     = fetch_insn_i.r_fmt.rs1;
    rs2_d     = fetch_insn_i.r_fmt.rs2;
    use_imm_d = 1'b0;
    we_d      = 1'b0;
    imm_d     = {{(XLEN - 8){fetch_insn_i.i_fmt.imm[7]}}, fetch_insn_i.i_fmt.imm};
    case (fetch_insn_i.r_fmt.opcode)
      OP_ADD: we_d = 1'b1;
      OP_SUB: begin
        op_d = ALU_SUB;
        we_d = 1'b1;
      end
      OP_AND: begin
        op_d = ALU_AND;
        we_d = 1'b1;
      end
      OP_XOR: begin
        op_d = ALU_XOR;
        we_d = 1'b1;
      end
      // LI adds the immediate to r0
      OP_LI: begin
        rs1_d     = '0;
        rs2_d     = '0;
        use_imm_d = 1'b1;
        we_d      = 1'b1;
      end
      OP_ADDI: begin
        rs1_d     = fetch_insn_i.i_fmt.rd;
        rs2_d     = '0;
        use_imm_d = 1'b1;
        we_d      = 1'b1;
      end
      default: begin
        rs1_d = '0;
        rs2_d = '0;
      end
    endcase
  end

  // Register read, bypassing the write committed this cycle
  assign rf_raddr_a_o = rs1_d;
  assign rf_raddr_b_o = rs2_d;
  assign a_d = (rf_we_i && rf_waddr_i == rs1_d) ? rf_wdata_i : rf_rdata_a_i;
  assign b_d = (rf_we_i && rf_waddr_i == rs2_d) ? rf_wdata_i : rf_rdata_b_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
      dec_we_o    <= 1'b0;
      dec_wfi_o   <= 1'b0;
    end else begin
      dec_valid_o <= fetched_q;
      dec_we_o    <= fetched_q & we_d;
      dec_wfi_o   <= is_wfi;
    end
  end

  always_ff @(posedge clk_i) begin
    dec_op_o      <= op_d;
    dec_rd_o      <= fetch_insn_i.r_fmt.rd;
    dec_rs1_o     <= rs1_d;
    dec_rs2_o     <= rs2_d;
    dec_a_o       <= a_d;
    dec_b_o       <= b_d;
    dec_use_imm_o <= use_imm_d;
    dec_imm_o     <= imm_d;
  end

endmodule

// ==== design/insn_execute.sv ====
/* Execute stage
   ALU with forwarding of its own previous result, output registered */
module insn_execute (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            dec_valid_i,
  input  mini_cluster_pkg::alu_op_e       dec_op_i,
  input  logic [3:0]                      dec_rd_i,
  input  logic [3:0]                      dec_rs1_i,
  input  logic [3:0]                      dec_rs2_i,
  input  logic [mini_cluster_pkg::XLEN-1:0] dec_a_i,
  input  logic [mini_cluster_pkg::XLEN-1:0] dec_b_i,
  input  logic                            dec_use_imm_i,
  input  logic [mini_cluster_pkg::XLEN-1:0] dec_imm_i,
  input  logic                            dec_we_i,
  input  logic                            dec_wfi_i,
  output logic                            ex_valid_o,
  output logic [3:0]                      ex_rd_o,
  output logic                            ex_we_o,
  output logic                            ex_wfi_o,
  output logic [mini_cluster_pkg::XLEN-1:0] ex_result_o
);

  import mini_cluster_pkg::*;

  logic            fwd_a;
  logic            fwd_b;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_res;

  // Previous result is not yet in the register file at decode time
  assign fwd_a = ex_we_o && (ex_rd_o != '0) && (ex_rd_o == dec_rs1_i);
  assign fwd_b = ex_we_o && (ex_rd_o != '0) && (ex_rd_o == dec_rs2_i);

  assign op_a = fwd_a ? ex_result_o : dec_a_i;
  assign op_b = dec_use_imm_i ? dec_imm_i : (fwd_b ? ex_result_o : dec_b_i);

  always_comb begin
    case (dec_op_i)
      ALU_SUB: alu_res = op_a - op_b;
      ALU_AND: alu_res = op_a & op_b;
      ALU_XOR: alu_res = op_a ^ op_b;
      default: alu_res = op_a + op_b;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_valid_o <= 1'b0;
      ex_we_o    <= 1'b0;
      ex_wfi_o   <= 1'b0;
    end else begin
      ex_valid_o <= dec_valid_i;
      ex_we_o    <= dec_valid_i & dec_we_i;
      ex_wfi_o   <= dec_valid_i & dec_wfi_i;
    end
  end

  always_ff @(posedge clk_i) begin
    ex_rd_o     <= dec_rd_i;
    ex_result_o <= alu_res;
  end

endmodule

// ==== design/insn_result.sv ====
/* Result stage
   Register file, write-back report and the sleep entry pulse */
module insn_result (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            ex_valid_i,
  input  logic [3:0]                      ex_rd_i,
  input  logic                            ex_we_i,
  input  logic                            ex_wfi_i,
  input  logic [mini_cluster_pkg::XLEN-1:0] ex_result_i,
  input  logic [3:0]                      rf_raddr_a_i,
  input  logic [3:0]                      rf_raddr_b_i,
  output logic [mini_cluster_pkg::XLEN-1:0] rf_rdata_a_o,
  output logic [mini_cluster_pkg::XLEN-1:0] rf_rdata_b_o,
  output logic                            rf_we_o,
  output logic [3:0]                      rf_waddr_o,
  output logic [mini_cluster_pkg::XLEN-1:0] rf_wdata_o,
  output logic                            sleep_enter_o,
  output logic                            wb_valid_o,
  output logic [3:0]                      wb_rd_o,
  output logic [mini_cluster_pkg::XLEN-1:0] wb_data_o
);

  import mini_cluster_pkg::*;

  logic [XLEN-1:0] regs_q [NrRegs];

  // r0 is never written, so it keeps reading zero
  assign rf_we_o    = ex_valid_i && ex_we_i && (ex_rd_i != '0);
  assign rf_waddr_o = ex_rd_i;
  assign rf_wdata_o = ex_result_i;

  always_ff @(posedge clk_i) begin
    if (rf_we_o) begin
      regs_q[rf_waddr_o] <= rf_wdata_o;
    end
  end

  assign rf_rdata_a_o = (rf_raddr_a_i == '0) ? '0 : regs_q[rf_raddr_a_i];
  assign rf_rdata_b_o = (rf_raddr_b_i == '0) ? '0 : regs_q[rf_raddr_b_i];

  // Writes to r0 are still reported
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_o    <= 1'b0;
      sleep_enter_o <= 1'b0;
    end else begin
      wb_valid_o    <= ex_valid_i & ex_we_i;
      sleep_enter_o <= ex_valid_i & ex_wfi_i;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_o   <= ex_rd_i;
    wb_data_o <= ex_result_i;
  end

endmodule

// ==== design/mini_cluster.sv ====
/* Mini cluster top
   Splits the bus between memory and peripherals, links the pipeline stages */
module mini_cluster (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    bus_we_i,
  input  logic [mini_cluster_pkg::BusAddrWidth-1:0] bus_addr_i,
  input  logic [mini_cluster_pkg::XLEN-1:0]         bus_wdata_i,
  output logic                                    wb_valid_o,
  output logic [3:0]                              wb_rd_o,
  output logic [mini_cluster_pkg::XLEN-1:0]         wb_data_o,
  output logic                                    sleep_o,
  output logic                                    msip_o
);

  import mini_cluster_pkg::*;

  logic               periph_sel;
  logic               mem_we;
  logic               periph_we;
  logic [PcWidth-1:0] entry_pc;
  logic               sleep_enter;
  logic               fetch_en;
  logic [PcWidth-1:0] fetch_pc;
  insn_u              fetch_insn;
  logic               rf_we;
  logic [3:0]         rf_waddr;
  logic [XLEN-1:0]    rf_wdata;
  logic [3:0]         rf_raddr_a;
  logic [3:0]         rf_raddr_b;
  logic [XLEN-1:0]    rf_rdata_a;
  logic [XLEN-1:0]    rf_rdata_b;
  logic               dec_valid;
  alu_op_e            dec_op;
  logic [3:0]         dec_rd;
  logic [3:0]         dec_rs1;
  logic [3:0]         dec_rs2;
  logic [XLEN-1:0]    dec_a;
  logic [XLEN-1:0]    dec_b;
  logic               dec_use_imm;
  logic [XLEN-1:0]    dec_imm;
  logic               dec_we;
  logic               dec_wfi;
  logic               ex_valid;
  logic [3:0]         ex_rd;
  logic               ex_we;
  logic               ex_wfi;
  logic [XLEN-1:0]    ex_result;

  // Top address bit picks the peripherals
  assign periph_sel = bus_addr_i[BusAddrWidth-1];
  assign mem_we     = bus_we_i & ~periph_sel;
  assign periph_we  = bus_we_i & periph_sel;

  cluster_periph i_periph (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .periph_we_i     (periph_we),
    .periph_offset_i (bus_addr_i[0]),
    .periph_wdata_i  (bus_wdata_i),
    .sleep_enter_i   (sleep_enter),
    .entry_pc_o      (entry_pc),
    .msip_o          (msip_o)
  );

  instr_mem i_imem (
    .clk_i        (clk_i),
    .mem_we_i     (mem_we),
    .mem_waddr_i  (bus_addr_i[PcWidth-1:0]),
    .mem_wdata_i  (bus_wdata_i),
    .fetch_en_i   (fetch_en),
    .fetch_pc_i   (fetch_pc),
    .fetch_insn_o (fetch_insn)
  );

  insn_decode i_decode (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .msip_i        (msip_o),
    .entry_pc_i    (entry_pc),
    .sleep_enter_i (sleep_enter),
    .fetch_insn_i  (fetch_insn),
    .rf_we_i       (rf_we),
    .rf_waddr_i    (rf_waddr),
    .rf_wdata_i    (rf_wdata),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .fetch_en_o    (fetch_en),
    .fetch_pc_o    (fetch_pc),
    .dec_valid_o   (dec_valid),
    .dec_op_o      (dec_op),
    .dec_rd_o      (dec_rd),
    .dec_rs1_o     (dec_rs1),
    .dec_rs2_o     (dec_rs2),
    .dec_a_o       (dec_a),
    .dec_b_o       (dec_b),
    .dec_use_imm_o (dec_use_imm),
    .dec_imm_o     (dec_imm),
    .dec_we_o      (dec_we),
    .dec_wfi_o     (dec_wfi),
    .sleep_o       (sleep_o)
  );

  insn_execute i_execute (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .dec_valid_i   (dec_valid),
    .dec_op_i      (dec_op),
    .dec_rd_i      (dec_rd),
    .dec_rs1_i     (dec_rs1),
    .dec_rs2_i     (dec_rs2),
    .dec_a_i       (dec_a),
    .dec_b_i       (dec_b),
    .dec_use_imm_i (dec_use_imm),
    .dec_imm_i     (dec_imm),
    .dec_we_i      (dec_we),
    .dec_wfi_i     (dec_wfi),
    .ex_valid_o    (ex_valid),
    .ex_rd_o       (ex_rd),
    .ex_we_o       (ex_we),
    .ex_wfi_o      (ex_wfi),
    .ex_result_o   (ex_result)
  );

  insn_result i_result (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ex_valid_i    (ex_valid),
    .ex_rd_i       (ex_rd),
    .ex_we_i       (ex_we),
    .ex_wfi_i      (ex_wfi),
    .ex_result_i   (ex_result),
    .rf_raddr_a_i  (rf_raddr_a),
    .rf_raddr_b_i  (rf_raddr_b),
    .rf_rdata_a_o  (rf_rdata_a),
    .rf_rdata_b_o  (rf_rdata_b),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .sleep_enter_o (sleep_enter),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

endmodule

// ==== dv/mini_cluster_asserts.sv ====
/* Cluster assertions
   Write-back, bus and msip rules checked on the top level */
module mini_cluster_asserts (
  input logic                                    clk_i,
  input logic                                    rst_n_i,
  input logic                                    bus_we_i,
  input logic [mini_cluster_pkg::BusAddrWidth-1:0] bus_addr_i,
  input logic [mini_cluster_pkg::XLEN-1:0]         bus_wdata_i,
  input logic                                    wb_valid_i,
  input logic                                    sleep_i,
  input logic                                    msip_i,
  input logic                                    sleep_enter_i
);

  import mini_cluster_pkg::*;

  int unsigned fail_cnt = 0;
  logic        imem_write;
  logic        msip_set;

  assign imem_write = bus_we_i && !bus_addr_i[BusAddrWidth-1];
  assign msip_set   = bus_we_i && bus_addr_i[BusAddrWidth-1]
                      && (bus_addr_i[0] == AddrMsip) && bus_wdata_i[0];

  a_no_wb_asleep : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> !sleep_i)
    else begin
      $error("write-back reported while the core sleeps");
      fail_cnt++;
    end

  a_imem_write_asleep : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    imem_write |-> sleep_i)
    else begin
      $error("instruction memory written while the core is awake");
      fail_cnt++;
    end

  // A bus write of 1 in the same cycle keeps msip set
  a_msip_clear : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sleep_enter_i && !msip_set) |=> !msip_i)
    else begin
      $error("msip still set after sleep entry");
      fail_cnt++;
    end

endmodule

bind mini_cluster mini_cluster_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_n_i       (rst_n_i),
  .bus_we_i      (bus_we_i),
  .bus_addr_i    (bus_addr_i),
  .bus_wdata_i   (bus_wdata_i),
  .wb_valid_i    (wb_valid_o),
  .sleep_i       (sleep_o),
  .msip_i        (msip_o),
  .sleep_enter_i (sleep_enter)
);

// ==== dv/tb_mini_cluster.sv ====
/* Mini cluster testbench
   Loads programs over the bus, wakes the core with msip and checks write-backs */
module tb_mini_cluster;

  import mini_cluster_pkg::*;

  localparam int NrTests  = 5;
  localparam int MaxWords = 40;

  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    bus_we;
  logic [BusAddrWidth-1:0] bus_addr;
  logic [XLEN-1:0]         bus_wdata;
  logic                    wb_valid;
  logic [3:0]              wb_rd;
  logic [XLEN-1:0]         wb_data;
  logic                    sleep;
  logic                    msip;

  // Test table; program words sit at their memory address
  string              test_name  [NrTests];
  logic [PcWidth-1:0] test_entry [NrTests];
  int                 test_len   [NrTests];
  logic [ILEN-1:0]    prog_words [2**PcWidth];
  logic [3:0]         exp_rd     [NrTests][MaxWords];
  logic [XLEN-1:0]    exp_data   [NrTests][MaxWords];
  int                 exp_cnt    [NrTests];
  logic [XLEN-1:0]    model_regs [NrRegs];

  integer seed        = 32'hccd2_92cd;
  int     errors      = 0;
  int     checks      = 0;
  int     cycles      = 0;
  int     cycle_limit = 0;

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout: run exceeded %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  mini_cluster uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data),
    .sleep_o     (sleep),
    .msip_o      (msip)
  );

  function automatic logic [ILEN-1:0] enc_r(logic [3:0] op, logic [3:0] rd,
                                            logic [3:0] rs1, logic [3:0] rs2);
    return {op, rd, rs1, rs2};
  endfunction

  function automatic logic [ILEN-1:0] enc_i(logic [3:0] op, logic [3:0] rd, logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  task automatic set_test(input int t, input string name, input logic [PcWidth-1:0] entry);
    test_name[t]  = name;
    test_entry[t] = entry;
    test_len[t]   = 0;
  endtask

  task automatic add_word(input int t, input logic [ILEN-1:0] word);
    prog_words[test_entry[t] + test_len[t]] = word;
    test_len[t]++;
  endtask

  task automatic build_tests;
    logic [31:0] rnd;
    logic [3:0]  op;
    int          sel;
    int          i;
    set_test(0, "li_addi", 8'h00);
    add_word(0, enc_i(OP_LI, 4'd1, 8'h05));
    add_word(0, enc_i(OP_LI, 4'd2, 8'hfd));
    add_word(0, enc_i(OP_ADDI, 4'd1, 8'h64));
    add_word(0, enc_i(OP_ADDI, 4'd2, 8'h80));
    add_word(0, enc_i(OP_LI, 4'd3, 8'h7f));
    add_word(0, enc_i(OP_ADDI, 4'd3, 8'h01));
    add_word(0, enc_i(OP_ADDI, 4'd3, 8'hff));
    add_word(0, enc_i(OP_WFI, 4'd0, 8'h00));
    // Consumers sit one and two slots behind their producers
    set_test(1, "reg_ops_fwd", 8'h20);
    add_word(1, enc_i(OP_LI, 4'd1, 8'h12));
    add_word(1, enc_i(OP_LI, 4'd2, 8'h34));
    add_word(1, enc_r(OP_ADD, 4'd3, 4'd1, 4'd2));
    add_word(1, enc_r(OP_SUB, 4'd4, 4'd3, 4'd1));
    add_word(1, enc_r(OP_AND, 4'd5, 4'd4, 4'd3));
    add_word(1, enc_r(OP_XOR, 4'd6, 4'd5, 4'd4));
    add_word(1, enc_r(OP_ADD, 4'd7, 4'd6, 4'd6));
    add_word(1, enc_r(OP_SUB, 4'd1, 4'd7, 4'd5));
    add_word(1, enc_r(OP_XOR, 4'd2, 4'd1, 4'd7));
    add_word(1, enc_i(OP_WFI, 4'd0, 8'h00));
    set_test(2, "r0_write", 8'h40);
    add_word(2, enc_i(OP_LI, 4'd1, 8'h09));
    add_word(2, enc_i(OP_LI, 4'd2, 8'h04));
    add_word(2, enc_r(OP_ADD, 4'd0, 4'd1, 4'd2));
    add_word(2, enc_r(OP_ADD, 4'd3, 4'd0, 4'd1));
    add_word(2, enc_i(OP_LI, 4'd0, 8'h55));
    add_word(2, enc_r(OP_XOR, 4'd4, 4'd0, 4'd2));
    add_word(2, enc_i(OP_ADDI, 4'd0, 8'h03));
    add_word(2, enc_r(OP_ADD, 4'd5, 4'd0, 4'd0));
    add_word(2, enc_i(OP_WFI, 4'd0, 8'h00));
    // Words after the first WFI must never retire
    set_test(3, "wfi_stop", 8'h60);
    add_word(3, enc_i(OP_LI, 4'd1, 8'h01));
    add_word(3, enc_i(OP_WFI, 4'd0, 8'h00));
    add_word(3, enc_i(OP_LI, 4'd1, 8'h02));
    add_word(3, enc_r(OP_ADD, 4'd2, 4'd1, 4'd1));
    add_word(3, enc_i(OP_WFI, 4'd0, 8'h00));
    set_test(4, "random_chain", 8'h80);
    for (i = 1; i <= 6; i++) begin
      rnd = $random(seed);
      add_word(4, enc_i(OP_LI, 4'(i), rnd[7:0]));
    end
    for (i = 0; i < 24; i++) begin
      rnd = $random(seed);
      sel = rnd[2:0] % 5;
      op  = (sel == 4) ? OP_ADDI : 4'(sel + 1);
      if (op == OP_ADDI) begin
        add_word(4, enc_i(op, 4'(1 + rnd[7:4] % 6), rnd[23:16]));
      end else begin
        add_word(4, enc_r(op, 4'(1 + rnd[7:4] % 6), 4'(1 + rnd[11:8] % 6),
                          4'(1 + rnd[15:12] % 6)));
      end
    end
    add_word(4, enc_i(OP_WFI, 4'd0, 8'h00));
  endtask

  task automatic record_wb(input int t, input logic [3:0] rd, input logic [XLEN-1:0] value);
    exp_rd[t][exp_cnt[t]]   = rd;
    exp_data[t][exp_cnt[t]] = value;
    exp_cnt[t]++;
    // r0 reports the write but keeps reading zero
    if (rd != 4'd0) begin
      model_regs[rd] = value;
    end
  endtask

  task automatic run_model(input int t);
    logic [ILEN-1:0] w;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            stop;
    int              i;
    exp_cnt[t] = 0;
    stop       = 1'b0;
    i          = 0;
    while (!stop && i < test_len[t]) begin
      w   = prog_words[test_entry[t] + i];
      imm = {{(XLEN - 8){w[7]}}, w[7:0]};
      a   = model_regs[w[7:4]];
      b   = model_regs[w[3:0]];
      case (w[15:12])
        OP_ADD:  record_wb(t, w[11:8], a + b);
        OP_SUB:  record_wb(t, w[11:8], a - b);
        OP_AND:  record_wb(t, w[11:8], a & b);
        OP_XOR:  record_wb(t, w[11:8], a ^ b);
        OP_LI:   record_wb(t, w[11:8], imm);
        OP_ADDI: record_wb(t, w[11:8], model_regs[w[11:8]] + imm);
        OP_WFI:  stop = 1'b1;
        default: ;
      endcase
      i++;
    end
  endtask

  task automatic bus_write(input logic [BusAddrWidth-1:0] addr, input logic [XLEN-1:0] data);
    @(negedge clk);
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
  endtask

  task automatic bus_idle;
    @(negedge clk);
    bus_we = 1'b0;
  endtask

  task automatic check_data(input string what, input logic [XLEN-1:0] expected,
                            input logic [XLEN-1:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("FAILED %s: expected 0x%04h, actual 0x%04h", what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_rd(input string what, input logic [3:0] expected, input logic [3:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("FAILED %s: expected r%0d, actual r%0d", what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      $display("FAILED %s: expected %0b, actual %0b", what, expected, actual);
      errors++;
    end
  endtask

  task automatic run_test(input int t);
    logic [PcWidth-1:0] waddr;
    int                 wb_seen;
    int                 errs_before;
    int                 i;
    errs_before = errors;
    wb_seen     = 0;
    while (!sleep) begin
      @(negedge clk);
    end
    for (i = 0; i < test_len[t]; i++) begin
      waddr = test_entry[t] + PcWidth'(i);
      bus_write({1'b0, waddr}, prog_words[waddr]);
    end
    bus_write({1'b1, 7'd0, AddrEntry}, XLEN'(test_entry[t]));
    bus_write({1'b1, 7'd0, AddrMsip}, 16'd1);
    bus_idle();
    while (sleep) begin
      @(negedge clk);
    end
    do begin
      @(negedge clk);
      if (wb_valid) begin
        if (wb_seen < exp_cnt[t]) begin
          check_rd($sformatf("%s wb %0d rd", test_name[t], wb_seen), exp_rd[t][wb_seen], wb_rd);
          check_data($sformatf("%s wb %0d data", test_name[t], wb_seen),
                     exp_data[t][wb_seen], wb_data);
        end
        wb_seen++;
      end
    end while (!sleep);
    check_bit($sformatf("%s msip after sleep", test_name[t]), 1'b0, msip);
    if (wb_seen != exp_cnt[t]) begin
      $display("%s: expected %0d write-backs but the core made %0d",
               test_name[t], exp_cnt[t], wb_seen);
      errors++;
    end
    $display("test %0d %s: %0d write-backs, %s", t, test_name[t], wb_seen,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int t;
    int total_words;
    rst_n       = 1'b0;
    bus_we      = 1'b0;
    bus_addr    = '0;
    bus_wdata   = '0;
    total_words = 0;
    build_tests();
    for (t = 0; t < NrRegs; t++) begin
      model_regs[t] = '0;
    end
    for (t = 0; t < NrTests; t++) begin
      run_model(t);
      total_words += test_len[t];
    end
    cycle_limit = 40 * total_words + 100 * NrTests;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    // Core must stay asleep and silent until msip is set
    repeat (10) begin
      @(negedge clk);
      check_bit("reset sleep", 1'b1, sleep);
      check_bit("reset msip", 1'b0, msip);
      check_bit("reset wb_valid", 1'b0, wb_valid);
    end
    for (t = 0; t < NrTests; t++) begin
      run_test(t);
    end
    errors += int'(uut.u_asserts.fail_cnt);
    $display("%0d tests, %0d checks, %0d errors", NrTests, checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== project.f ====
design/mini_cluster_pkg.sv
design/cluster_periph.sv
design/instr_mem.sv
design/insn_decode.sv
design/insn_execute.sv
design/insn_result.sv
design/mini_cluster.sv
dv/mini_cluster_asserts.sv
dv/tb_mini_cluster.sv

// ==== Bender.yml ====
package:
  name: mini_cluster

sources:
  - design/mini_cluster_pkg.sv
  - design/cluster_periph.sv
  - design/instr_mem.sv
  - design/insn_decode.sv
  - design/insn_execute.sv
  - design/insn_result.sv
  - design/mini_cluster.sv
  - target: simulation
    files:
      - dv/mini_cluster_asserts.sv
      - dv/tb_mini_cluster.sv
